//--- synth_audio_testdata.txt
// Columns: level0..level7, left mask, right mask, atten, expected left, expected right
// All values hex, levels and samples are signed 16-bit
0000 0000 0000 0000 0000 0000 0000 0000 00ff 00ff 0000 0000 0000
0100 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0100 0000
0100 0200 0000 0000 0000 0000 0000 0000 0001 0002 0000 0100 0200
0001 0002 0003 0004 0005 0006 0007 0008 00ff 00ff 0000 0024 0024
0001 0002 0003 0004 0005 0006 0007 0008 000f 00f0 0000 000a 001a
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 00ff 00ff 0000 7fff 7fff
4000 4000 4000 4000 4000 4000 4000 4000 00ff 00ff 0002 7fff 7fff
4000 4000 4000 4000 4000 4000 4000 4000 00ff 000f 0003 4000 2000
8000 8000 8000 8000 8000 8000 8000 8000 00ff 00ff 0001 8000 8000
7fff 7fff 8001 0000 0000 0000 0000 0000 0007 0006 0000 7fff 0000
fffd 0000 0000 0000 0000 0000 0000 0000 0001 0000 0001 fffe 0000
1000 2000 3000 4000 f000 e000 d000 c000 000f 00f0 0000 7fff 8000
1000 2000 3000 4000 f000 e000 d000 c000 000f 00f0 0001 5000 b000
1000 2000 3000 4000 f000 e000 d000 c000 003f 00fc 0000 7000 d000
1000 2000 3000 4000 f000 e000 d000 c000 0081 0018 0002 f400 0c00

//--- project.f
synth_audio_pkg.sv
audio_clk_gen.sv
voice_reg_decode.sv
voice_mixer.sv
i2s_serializer.sv
synth_audio_top.sv
synth_audio_asserts.sv
tb_synth_audio.sv

//--- Bender.yml
package:
  name: synth_audio

sources:
  - synth_audio_pkg.sv
  - audio_clk_gen.sv
  - voice_reg_decode.sv
  - voice_mixer.sv
  - i2s_serializer.sv
  - synth_audio_top.sv
  - target: test
    files:
      - synth_audio_asserts.sv
      - tb_synth_audio.sv

//--- tb_synth_audio.sv
`timescale 1ns/10ps

module tb_synth_audio;
    import synth_audio_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int VEC_WORDS    = 13;   // 8 levels, 2 masks, atten, 2 expected
    localparam int MAX_VEC      = 32;
    localparam int N_RAND       = 12;
    localparam int FRAME_CYCLES = 2 * LRCK_HALF;

    logic        AUDIO_CLK;
    logic        reset_reg_N;
    logic        reg_wr;
    reg_addr_t   reg_addr;
    sample_t     reg_wdata;
    logic        aud_lrck;
    logic        aud_bclk;
    logic        aud_dacdat;
    logic        bad_addr;

    logic [16:0] vec_mem [MAX_VEC*VEC_WORDS];   // Bit 16 set means never loaded
    int          n_vec;
    logic        vec_loaded;
    sample_t     lvl [VOICES];                  // Setup currently programmed
    voice_mask_t lmask;
    voice_mask_t rmask;
    atten_t      att;
    logic [31:0] rng_state;
    int          sample_errors;
    int          flag_errors;
    int          count_errors;
    int          other_errors;

    synth_audio_top uut (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .aud_lrck    (aud_lrck),
        .aud_bclk    (aud_bclk),
        .aud_dacdat  (aud_dacdat),
        .bad_addr    (bad_addr)
    );

    always #(CLK_PERIOD/2) AUDIO_CLK = ~AUDIO_CLK;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected)
        begin
            sample_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            flag_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            count_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // 32-bit xorshift
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Reference: masked sum, arithmetic shift, clamp to 16 bits
    function automatic sample_t predict_mix(input voice_mask_t mask, input atten_t sh);
        int sum;
        sum = 0;
        for (int v = 0; v < VOICES; v++)
            if (mask[v])
                sum = sum + int'(lvl[v]);   // Sign extended
        sum = sum >>> sh;
        if (sum > 32767)
            return 16'sh7FFF;
        else if (sum < -32768)
            return 16'sh8000;
        return sample_t'(sum);
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus and DAC side tasks
    ////////////////////////////////////////////////////////////
    task automatic reg_write(input reg_addr_t addr, input sample_t data, input logic expect_bad);
        @(negedge AUDIO_CLK);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge AUDIO_CLK);
        reg_wr = 1'b0;
        check_flag($sformatf("bad_addr after write to %0d", addr), expect_bad, bad_addr);
    endtask

    task automatic program_config();
        for (int v = 0; v < VOICES; v++)
            reg_write(reg_addr_t'(REG_LEVEL_BASE + v), lvl[v], 1'b0);
        reg_write(REG_LEFT_MASK, {8'h00, lmask}, 1'b0);
        reg_write(REG_RIGHT_MASK, {8'h00, rmask}, 1'b0);
        reg_write(REG_ATTEN, {14'h0000, att}, 1'b0);
    endtask

    // One frame from the LRCK fall, first rising BCLK still holds the old LSB
    task automatic capture_frame(output sample_t left, output sample_t right);
        logic [31:0] bits;
        bits = '0;
        @(negedge aud_lrck);
        @(posedge aud_bclk);
        for (int i = 0; i < 32; i++)
        begin
            @(posedge aud_bclk);
            bits = {bits[30:0], aud_dacdat};   // MSB first
        end
        left  = bits[31:16];
        right = bits[15:0];
    endtask

    task automatic run_config(input string name, input sample_t exp_l, input sample_t exp_r);
        sample_t got_l;
        sample_t got_r;
        program_config();
        @(negedge aud_lrck);   // Mixing frame
        capture_frame(got_l, got_r);
        check_sample({name, " left"}, exp_l, got_l);
        check_sample({name, " right"}, exp_r, got_r);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        int      base;
        int      cyc;
        int      bclk_rises;
        int      total;
        logic    prev_b;
        logic    prev_l;
        logic    done;
        sample_t got_l;
        sample_t got_r;
        logic [31:0] r;

        AUDIO_CLK     = 1'b0;
        reset_reg_N   = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        rng_state     = 32'd53;
        sample_errors = 0;
        flag_errors   = 0;
        count_errors  = 0;
        other_errors  = 0;
        vec_loaded    = 1'b0;

        for (int i = 0; i < MAX_VEC*VEC_WORDS; i++)
            vec_mem[i] = {1'b1, 16'(i)};
        $readmemh("synth_audio_testdata.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_WORDS + VEC_WORDS - 1][16] == 1'b0)
            n_vec++;
        if (n_vec == 0)
        begin
            other_errors++;
            $display("No complete vectors found in synth_audio_testdata.txt");
        end
        vec_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge AUDIO_CLK);
        check_flag("lrck in reset", 1'b0, aud_lrck);
        check_flag("bclk in reset", 1'b0, aud_bclk);
        check_flag("dacdat in reset", 1'b0, aud_dacdat);
        check_flag("bad_addr in reset", 1'b0, bad_addr);
        reset_reg_N = 1'b1;

        // Quiet until LRCK first rises
        while (aud_lrck !== 1'b1)
        begin
            check_flag("dacdat before first frame", 1'b0, aud_dacdat);
            check_flag("bad_addr before first frame", 1'b0, bad_addr);
            @(negedge AUDIO_CLK);
        end

        // One LRCK period, rise to rise
        cyc        = 0;
        bclk_rises = 0;
        prev_b     = aud_bclk;
        prev_l     = aud_lrck;
        done       = 1'b0;
        while (!done)
        begin
            @(negedge AUDIO_CLK);
            cyc++;
            if (aud_bclk && !prev_b)
                bclk_rises++;
            if (aud_lrck && !prev_l)
                done = 1'b1;
            prev_b = aud_bclk;
            prev_l = aud_lrck;
        end
        check_count("lrck period", FRAME_CYCLES, cyc);
        check_count("bclk periods per frame", FRAME_CYCLES / (2 * BCK_HALF), bclk_rises);

        // Directed vectors from file
        for (int n = 0; n < n_vec; n++)
        begin
            base = n * VEC_WORDS;
            for (int v = 0; v < VOICES; v++)
                lvl[v] = vec_mem[base + v][15:0];
            lmask = vec_mem[base + 8][7:0];
            rmask = vec_mem[base + 9][7:0];
            att   = vec_mem[base + 10][1:0];
            run_config($sformatf("vec%0d", n), vec_mem[base + 11][15:0],
                       vec_mem[base + 12][15:0]);
        end

        // Invalid addresses, last directed setup must survive
        if (n_vec > 0)
        begin
            base = (n_vec - 1) * VEC_WORDS;
            for (int a = REG_ATTEN + 1; a < 16; a++)
            begin
                reg_write(reg_addr_t'(a), 16'shFFFF, 1'b1);
                @(negedge AUDIO_CLK);
                check_flag("bad_addr clears", 1'b0, bad_addr);
            end
            @(negedge aud_lrck);
            capture_frame(got_l, got_r);
            check_sample("bad writes left", vec_mem[base + 11][15:0], got_l);
            check_sample("bad writes right", vec_mem[base + 12][15:0], got_r);
        end

        // Random setups against the reference
        for (int n = 0; n < N_RAND; n++)
        begin
            for (int v = 0; v < VOICES; v++)
            begin
                r      = xorshift32();
                lvl[v] = r[15:0];
            end
            r     = xorshift32();
            lmask = r[7:0];
            rmask = r[15:8];
            att   = r[17:16];
            run_config($sformatf("rand%0d", n), predict_mix(lmask, att), predict_mix(rmask, att));
        end

        total = sample_errors + flag_errors + count_errors + other_errors
              + uut.u_asserts.assert_errors;
        $display("Error counts: sample %0d, flag %0d, count %0d, other %0d, assertion %0d",
                 sample_errors, flag_errors, count_errors, other_errors,
                 uut.u_asserts.assert_errors);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog, about three frames per setup
    initial
    begin
        int limit_cycles;
        wait (vec_loaded === 1'b1);
        limit_cycles = (n_vec + N_RAND + 3) * 3 * FRAME_CYCLES + 4000;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: run still busy after %0d clock cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- synth_audio_asserts.sv
`timescale 1ns/10ps

module synth_audio_asserts (
    input logic                       AUDIO_CLK,
    input logic                       reset_reg_N,
    input logic                       reg_wr,
    input synth_audio_pkg::reg_addr_t reg_addr,
    input logic                       aud_lrck,
    input logic                       aud_bclk,
    input logic                       aud_dacdat,
    input logic                       bad_addr
);
    import synth_audio_pkg::*;

    int   assert_errors = 0;   // Failure count
    logic bad_wr;

    assign bad_wr = reg_wr && (reg_addr > REG_ATTEN);   // 11 to 15

    ////////////////////////////////////////////////////////////
    // I2S edge alignment
    ////////////////////////////////////////////////////////////
    dacdat_on_bclk_fall: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        $changed(aud_dacdat) |-> $fell(aud_bclk))
    else
    begin
        $error("aud_dacdat changed without a falling aud_bclk");
        assert_errors++;
    end

    lrck_on_bclk_fall: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        $changed(aud_lrck) |-> $fell(aud_bclk))
    else
    begin
        $error("aud_lrck changed without a falling aud_bclk");
        assert_errors++;
    end

    // Two-cycle pulse only from back-to-back bad writes
    bad_addr_single_pulse: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        bad_addr && $past(bad_addr) |-> $past(bad_wr) && $past(bad_wr, 2))
    else
    begin
        $error("bad_addr high two cycles without two invalid writes");
        assert_errors++;
    end

endmodule

bind synth_audio_top synth_audio_asserts u_asserts (
    .AUDIO_CLK   (AUDIO_CLK),
    .reset_reg_N (reset_reg_N),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .aud_lrck    (aud_lrck),
    .aud_bclk    (aud_bclk),
    .aud_dacdat  (aud_dacdat),
    .bad_addr    (bad_addr)
);

//--- synth_audio_top.sv
`timescale 1ns/10ps

module synth_audio_top (
    input  logic                      AUDIO_CLK,
    input  logic                      reset_reg_N,
    input  logic                      reg_wr,
    input  synth_audio_pkg::reg_addr_t reg_addr,
    input  synth_audio_pkg::sample_t   reg_wdata,
    output logic                      aud_lrck,
    output logic                      aud_bclk,
    output logic                      aud_dacdat,
    output logic                      bad_addr
);
    import synth_audio_pkg::*;

    logic        frame_start;   // Start of left channel
    logic        bclk_fall;
    voice_idx_t  voice_idx;
    sample_t     voice_level;
    voice_mask_t left_mask;
    voice_mask_t right_mask;
    atten_t      atten;
    sample_t     mix_left;
    sample_t     mix_right;
    logic        mix_valid;

    //////////////////////////////////////////////////////////////
    // Clocking, registers, mixing, DAC output
    //////////////////////////////////////////////////////////////
    audio_clk_gen u_clk_gen (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .aud_lrck    (aud_lrck),
        .aud_bclk    (aud_bclk),
        .frame_start (frame_start),
        .bclk_fall   (bclk_fall)
    );

    voice_reg_decode u_decode (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .voice_idx   (voice_idx),
        .voice_level (voice_level),
        .left_mask   (left_mask),
        .right_mask  (right_mask),
        .atten       (atten),
        .bad_addr    (bad_addr)
    );

    voice_mixer u_execute (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .frame_start (frame_start),
        .voice_level (voice_level),
        .left_mask   (left_mask),
        .right_mask  (right_mask),
        .atten       (atten),
        .voice_idx   (voice_idx),
        .mix_left    (mix_left),
        .mix_right   (mix_right),
        .mix_valid   (mix_valid)
    );

    i2s_serializer u_result (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .frame_start (frame_start),
        .bclk_fall   (bclk_fall),
        .mix_left    (mix_left),
        .mix_right   (mix_right),
        .mix_valid   (mix_valid),
        .aud_dacdat  (aud_dacdat)
    );

endmodule

//--- i2s_serializer.sv
`timescale 1ns/10ps

module i2s_serializer (
    input  logic                    AUDIO_CLK,
    input  logic                    reset_reg_N,
    input  logic                    frame_start,
    input  logic                    bclk_fall,
    input  synth_audio_pkg::sample_t mix_left,
    input  synth_audio_pkg::sample_t mix_right,
    input  logic                    mix_valid,
    output logic                    aud_dacdat
);
    import synth_audio_pkg::*;

    sample_t                hold_left;     // Last finished mix
    sample_t                hold_right;
    logic [FRAME_BITS-1:0]  shreg;         // Left MSB on top
    logic [FRAME_CNT_W-1:0] bit_cnt;       // Bits sent this frame
    logic                   shift_en;

    // Stop after a full frame if the next load is late
    assign shift_en = bclk_fall && (bit_cnt != FRAME_CNT_W'(FRAME_BITS));

    //////////////////////////////////////////////////////////////
    // Load and shift
    //////////////////////////////////////////////////////////////
    // Load lands between the LRCK edge and the next BCLK fall
    // The fall on each LRCK edge still carries the previous LSB
    // which gives the one-bit I2S delay on both channels
    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            hold_left  <= '0;
            hold_right <= '0;
            shreg      <= '0;
            bit_cnt    <= '0;
            aud_dacdat <= 1'b0;
        end
        else
        begin
            if (mix_valid)
            begin
                hold_left  <= mix_left;
                hold_right <= mix_right;
            end

            if (frame_start)
            begin
                shreg   <= {hold_left, hold_right};   // Previous frame's mix
                bit_cnt <= '0;
            end
            else if (shift_en)
            begin
                aud_dacdat <= shreg[FRAME_BITS-1];     // Changes with BCLK fall
                shreg      <= {shreg[FRAME_BITS-2:0], 1'b0};
                bit_cnt    <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- voice_mixer.sv
`timescale 1ns/10ps

module voice_mixer (
    input  logic                        AUDIO_CLK,
    input  logic                        reset_reg_N,
    input  logic                        frame_start,
    input  synth_audio_pkg::sample_t     voice_level,
    input  synth_audio_pkg::voice_mask_t left_mask,
    input  synth_audio_pkg::voice_mask_t right_mask,
    input  synth_audio_pkg::atten_t      atten,
    output synth_audio_pkg::voice_idx_t  voice_idx,
    output synth_audio_pkg::sample_t     mix_left,
    output synth_audio_pkg::sample_t     mix_right,
    output logic                        mix_valid
);
    import synth_audio_pkg::*;

    mix_state_e state;
    mix_acc_t   acc_left;
    mix_acc_t   acc_right;
    mix_acc_t   lvl_ext;     // Sign extended level
    mix_acc_t   add_left;
    mix_acc_t   add_right;

    // Shift first, then clamp to 16 bits
    function automatic sample_t atten_sat(input mix_acc_t sum, input atten_t sh);
        mix_acc_t shifted;
        shifted = sum >>> sh;
        if (shifted > mix_acc_t'(SAMPLE_MAX))
            return SAMPLE_MAX;
        else if (shifted < mix_acc_t'(SAMPLE_MIN))
            return SAMPLE_MIN;
        else
            return sample_t'(shifted);
    endfunction

    assign lvl_ext   = mix_acc_t'(voice_level);
    assign add_left  = left_mask[voice_idx]  ? lvl_ext : '0;   // Masked off adds zero
    assign add_right = right_mask[voice_idx] ? lvl_ext : '0;

    //////////////////////////////////////////////////////////////
    // Voice walk, voice 0 is summed in the frame_start cycle
    //////////////////////////////////////////////////////////////
    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            state     <= MIX_IDLE;
            voice_idx <= '0;
            acc_left  <= '0;
            acc_right <= '0;
            mix_left  <= '0;
            mix_right <= '0;
            mix_valid <= 1'b0;
        end
        else
        begin
            mix_valid <= 1'b0;
            case (state)
                MIX_IDLE:
                begin
                    if (frame_start)
                    begin
                        acc_left  <= add_left;    // Fresh sum
                        acc_right <= add_right;
                        voice_idx <= voice_idx + 1'b1;
                        state     <= MIX_ACCUM;
                    end
                end
                MIX_ACCUM:   // frame_start ignored here
                begin
                    acc_left  <= acc_left + add_left;
                    acc_right <= acc_right + add_right;
                    if (voice_idx == voice_idx_t'(VOICES - 1))
                    begin
                        voice_idx <= '0;
                        state     <= MIX_DONE;
                    end
                    else
                        voice_idx <= voice_idx + 1'b1;
                end
                MIX_DONE:
                begin
                    mix_left  <= atten_sat(acc_left, atten);
                    mix_right <= atten_sat(acc_right, atten);
                    mix_valid <= 1'b1;     // 9 cycles after frame_start
                    state     <= MIX_IDLE;
                end
                default:
                    state <= MIX_IDLE;
            endcase
        end
    end

endmodule

//--- voice_reg_decode.sv
`timescale 1ns/10ps

module voice_reg_decode (
    input  logic                        AUDIO_CLK,
    input  logic                        reset_reg_N,
    input  logic                        reg_wr,
    input  synth_audio_pkg::reg_addr_t   reg_addr,
    input  synth_audio_pkg::sample_t     reg_wdata,
    input  synth_audio_pkg::voice_idx_t  voice_idx,
    output synth_audio_pkg::sample_t     voice_level,
    output synth_audio_pkg::voice_mask_t left_mask,
    output synth_audio_pkg::voice_mask_t right_mask,
    output synth_audio_pkg::atten_t      atten,
    output logic                        bad_addr
);
    import synth_audio_pkg::*;

    sample_t   level_q [VOICES];   // One level per voice
    reg_addr_t lvl_off;
    logic      wr_level;
    logic      wr_left;
    logic      wr_right;
    logic      wr_atten;
    logic      wr_bad;

    // Address decode
    assign lvl_off  = reg_addr - REG_LEVEL_BASE;
    assign wr_level = reg_wr && (lvl_off < reg_addr_t'(VOICES));
    assign wr_left  = reg_wr && (reg_addr == REG_LEFT_MASK);
    assign wr_right = reg_wr && (reg_addr == REG_RIGHT_MASK);
    assign wr_atten = reg_wr && (reg_addr == REG_ATTEN);
    assign wr_bad   = reg_wr && (reg_addr > REG_ATTEN);   // 11 to 15

    assign voice_level = level_q[voice_idx];  // Mixer read port

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            for (int i = 0; i < VOICES; i++)
                level_q[i] <= '0;
            left_mask  <= '0;
            right_mask <= '0;
            atten      <= '0;
            bad_addr   <= 1'b0;
        end
        else
        begin
            if (wr_level)
                level_q[voice_idx_t'(lvl_off)] <= reg_wdata;
            if (wr_left)
                left_mask <= reg_wdata[VOICES-1:0];   // Low byte only
            if (wr_right)
                right_mask <= reg_wdata[VOICES-1:0];
            if (wr_atten)
                atten <= reg_wdata[1:0];
            bad_addr <= wr_bad;   // Pulse, nothing else touched
        end
    end

endmodule

//--- audio_clk_gen.sv
`timescale 1ns/10ps

module audio_clk_gen (
    input  logic AUDIO_CLK,
    input  logic reset_reg_N,
    output logic aud_lrck,
    output logic aud_bclk,
    output logic frame_start,
    output logic bclk_fall
);
    import synth_audio_pkg::*;

    logic [LRCK_CNT_W-1:0] lrck_cnt;   // Frame clock compare counter
    logic [BCK_CNT_W-1:0]  bck_cnt;    // Bit clock compare counter
    logic                  lrck_tick;
    logic                  bck_tick;

    // Compare hits, the outputs toggle on these
    assign lrck_tick = (lrck_cnt >= LRCK_CNT_W'(LRCK_HALF));
    assign bck_tick  = (bck_cnt >= BCK_CNT_W'(BCK_HALF));

    // High in the cycle that ends with BCLK dropping
    // Lets the serializer update data on the same edge
    assign bclk_fall = bck_tick & aud_bclk;

    //////////////////////////////////////////////////////////////
    // Divide-by-compare counters
    //////////////////////////////////////////////////////////////
    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            lrck_cnt    <= '0;
            bck_cnt     <= '0;
            aud_lrck    <= 1'b0;
            aud_bclk    <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            // LRCK
            if (lrck_tick)
            begin
                lrck_cnt <= LRCK_CNT_W'(1);   // Reload, not zero
                aud_lrck <= ~aud_lrck;
            end
            else
                lrck_cnt <= lrck_cnt + 1'b1;

            // BCLK
            if (bck_tick)
            begin
                bck_cnt  <= BCK_CNT_W'(1);
                aud_bclk <= ~aud_bclk;
            end
            else
                bck_cnt <= bck_cnt + 1'b1;

            frame_start <= lrck_tick & aud_lrck;  // First cycle of left channel
        end
    end

endmodule

//--- synth_audio_pkg.sv
package synth_audio_pkg;

    //////////////////////////////////////////////////////////////
    // Widths and divider constants
    //////////////////////////////////////////////////////////////
    localparam int VOICES      = 8;
    localparam int DATA_WIDTH  = 16;
    localparam int ACC_WIDTH   = DATA_WIDTH + $clog2(VOICES);  // Headroom for eight voices
    localparam int LRCK_HALF   = 32;                     // AUDIO_CLK cycles per LRCK half
    localparam int BCK_HALF    = 1;                      // AUDIO_CLK cycles per BCLK half
    localparam int LRCK_CNT_W  = $clog2(LRCK_HALF + 1);
    localparam int BCK_CNT_W   = $clog2(BCK_HALF + 1);
    localparam int FRAME_BITS  = 2 * DATA_WIDTH;         // Left then right
    localparam int FRAME_CNT_W = $clog2(FRAME_BITS + 1);

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef logic signed [ACC_WIDTH-1:0]  mix_acc_t;
    typedef logic [VOICES-1:0]            voice_mask_t;
    typedef logic [$clog2(VOICES)-1:0]    voice_idx_t;
    typedef logic [3:0]                   reg_addr_t;
    typedef logic [1:0]                   atten_t;

    // Full scale limits for the saturating output
    localparam sample_t SAMPLE_MAX = 16'sh7FFF;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    //////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////
    localparam reg_addr_t REG_LEVEL_BASE = 4'd0;  // Levels at 0 to 7
    localparam reg_addr_t REG_LEFT_MASK  = 4'd8;
    localparam reg_addr_t REG_RIGHT_MASK = 4'd9;
    localparam reg_addr_t REG_ATTEN      = 4'd10; // Anything above is invalid

    // Mixer sequencing
    typedef enum logic [1:0] {MIX_IDLE, MIX_ACCUM, MIX_DONE} mix_state_e;

endpackage
